// File: list.f
common/rvseed_pkg.sv
rtl/alu.sv
rtl/rvseed_regfile.sv
mem/data_mem.sv
rtl/ex_pipe.sv
rtl/rvseed_ex_top.sv
bench/rvseed_ex_assert.sv
bench/tb_rvseed_ex.sv

// File: bench/tb_rvseed_ex.sv
`default_nettype none

module tb_rvseed_ex;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS   = 64;
    localparam int N_ALU       = 200;
    localparam int N_WORD      = 100;
    localparam int N_BR        = 80;
    localparam int N_LDST      = 160;
    localparam int N_FWD       = 40; // chains of four ops
    localparam int N_FIXED     = 24; // hand-picked corner ops, upper bound
    localparam int TOTAL_OPS   = 31 + N_ALU + N_WORD + N_BR + MEM_WORDS + N_LDST +
                                 4 * N_FWD + N_FIXED;
    localparam int CYCLE_LIMIT = 2 * (TOTAL_OPS + 50);

    typedef struct packed {
        logic            is_br;
        logic            taken;
        rvseed_pkg::wb_t wb;
    } expect_t;

    logic                        clk;
    logic                        arst_n;
    logic                        issue;
    rvseed_pkg::ex_req_t         req;
    logic                        wb_valid;
    rvseed_pkg::wb_t             wb;
    logic                        br_valid;
    logic                        br_taken;

    logic [rvseed_pkg::XLEN-1:0] m_regs [32]; // reference register file
    logic [rvseed_pkg::XLEN-1:0] m_mem [MEM_WORDS];
    expect_t                     exp_q [$];
    expect_t                     head;
    integer                      seed;
    int                          cycles;
    int                          drain;

    rvseed_ex_top #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .issue    (issue),
        .req      (req),
        .wb_valid (wb_valid),
        .wb       (wb),
        .br_valid (br_valid),
        .br_taken (br_taken)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping on first error");
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                abort_run($sformatf("timeout: run did not finish within %0d cycles",
                                    CYCLE_LIMIT));
            end
        end
    end

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    function automatic rvseed_pkg::reg_idx_t rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic rvseed_pkg::reg_idx_t rand_dest();
        rvseed_pkg::reg_idx_t r;
        r = rand_reg();
        return (r == '0) ? 5'd1 : r; // never x0
    endfunction

    // 0..9 plain alu, 10..13 word and divide, 14..16 branches
    function automatic rvseed_pkg::alu_op_e pick_op(input int sel);
        case (sel)
            0:       return rvseed_pkg::ALU_ADD;
            1:       return rvseed_pkg::ALU_SUB;
            2:       return rvseed_pkg::ALU_AND;
            3:       return rvseed_pkg::ALU_OR;
            4:       return rvseed_pkg::ALU_XOR;
            5:       return rvseed_pkg::ALU_SLL;
            6:       return rvseed_pkg::ALU_SRA;
            7:       return rvseed_pkg::ALU_SLTU;
            8:       return rvseed_pkg::ALU_SLT;
            9:       return rvseed_pkg::ALU_MUL;
            10:      return rvseed_pkg::ALU_ADDW;
            11:      return rvseed_pkg::ALU_SLLW;
            12:      return rvseed_pkg::ALU_DIVW;
            13:      return rvseed_pkg::ALU_REMU;
            14:      return rvseed_pkg::ALU_BEQ;
            15:      return rvseed_pkg::ALU_BNE;
            default: return rvseed_pkg::ALU_BLT;
        endcase
    endfunction

    function automatic rvseed_pkg::mem_op_e rand_load();
        int k;
        k = rand_below(3);
        if (k == 0) begin
            return rvseed_pkg::MEM_LD;
        end else if (k == 1) begin
            return rvseed_pkg::MEM_LWU;
        end else begin
            return rvseed_pkg::MEM_LBU;
        end
    endfunction

    function automatic logic is_branch_op(input rvseed_pkg::alu_op_e op);
        return (op == rvseed_pkg::ALU_BEQ) || (op == rvseed_pkg::ALU_BNE) ||
               (op == rvseed_pkg::ALU_BLT);
    endfunction

    function automatic logic [63:0] exp_alu(input rvseed_pkg::alu_op_e op,
                                            input logic [63:0] a, input logic [63:0] b,
                                            output logic tk);
        logic [63:0] r;
        logic [31:0] w;
        longint      q;
        r  = '0;
        w  = '0;
        tk = 1'b0;
        case (op)
            rvseed_pkg::ALU_ADD:  r = a + b;
            rvseed_pkg::ALU_SUB:  r = a - b;
            rvseed_pkg::ALU_AND:  r = a & b;
            rvseed_pkg::ALU_OR:   r = a | b;
            rvseed_pkg::ALU_XOR:  r = a ^ b;
            rvseed_pkg::ALU_SLL:  r = a << b[5:0];
            rvseed_pkg::ALU_SRA:  r = $signed(a) >>> b[5:0];
            rvseed_pkg::ALU_SLTU: r = (a < b) ? 64'd1 : 64'd0;
            rvseed_pkg::ALU_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            rvseed_pkg::ALU_MUL:  r = a * b;
            rvseed_pkg::ALU_ADDW: begin
                w = a[31:0] + b[31:0];
                r = {{32{w[31]}}, w};
            end
            rvseed_pkg::ALU_SLLW: begin
                w = a[31:0] << b[4:0];
                r = {{32{w[31]}}, w};
            end
            rvseed_pkg::ALU_DIVW: begin
                if (b[31:0] == 32'd0) begin
                    r = '1;
                end else begin
                    q = longint'($signed(a[31:0])) / longint'($signed(b[31:0])); // no overflow
                    w = q[31:0];
                    r = {{32{w[31]}}, w};
                end
            end
            rvseed_pkg::ALU_REMU: r = (b == 64'd0) ? a : a % b;
            rvseed_pkg::ALU_BEQ:  tk = (a == b);
            rvseed_pkg::ALU_BNE:  tk = (a != b);
            rvseed_pkg::ALU_BLT:  tk = ($signed(a) < $signed(b));
            default:              r = '0;
        endcase
        return r;
    endfunction

    function automatic rvseed_pkg::ex_req_t rr_req(input rvseed_pkg::alu_op_e op,
        input rvseed_pkg::reg_idx_t rd, input rvseed_pkg::reg_idx_t rs1,
        input rvseed_pkg::reg_idx_t rs2);
        rvseed_pkg::ex_req_t r;
        r        = '0;
        r.alu_op = op;
        r.mem_op = rvseed_pkg::MEM_NONE;
        r.rd     = rd;
        r.rs1    = rs1;
        r.rs2    = rs2;
        return r;
    endfunction

    function automatic rvseed_pkg::ex_req_t imm_req(input rvseed_pkg::alu_op_e op,
        input rvseed_pkg::reg_idx_t rd, input rvseed_pkg::reg_idx_t rs1,
        input logic [63:0] imm);
        rvseed_pkg::ex_req_t r;
        r         = rr_req(op, rd, rs1, 5'd0);
        r.use_imm = 1'b1;
        r.imm     = imm;
        return r;
    endfunction

    function automatic rvseed_pkg::ex_req_t mem_req(input rvseed_pkg::mem_op_e mop,
        input rvseed_pkg::reg_idx_t rd, input rvseed_pkg::reg_idx_t rs1,
        input rvseed_pkg::reg_idx_t rs2, input logic [63:0] imm);
        rvseed_pkg::ex_req_t r;
        r        = imm_req(rvseed_pkg::ALU_ADD, rd, rs1, imm);
        r.mem_op = mop;
        r.rs2    = rs2; // store data source
        return r;
    endfunction

    // update the model in issue order, then drive the request
    task automatic send(input rvseed_pkg::ex_req_t r);
        expect_t     e;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] res;
        logic [63:0] dword;
        logic [63:0] data;
        logic        tk;
        int          idx;
        a     = m_regs[r.rs1];
        b     = r.use_imm ? r.imm : m_regs[r.rs2];
        res   = exp_alu(r.alu_op, a, b, tk);
        idx   = int'((res >> 3) % MEM_WORDS);
        dword = m_mem[idx];
        e     = '0;
        if (is_branch_op(r.alu_op)) begin
            e.is_br = 1'b1;
            e.taken = tk;
        end else if (r.mem_op == rvseed_pkg::MEM_SD) begin
            e.wb.rd     = r.rd;
            m_mem[idx]  = m_regs[r.rs2];
        end else begin
            case (r.mem_op)
                rvseed_pkg::MEM_LD:  data = dword;
                rvseed_pkg::MEM_LWU: data = res[2] ? {32'd0, dword[63:32]} : {32'd0, dword[31:0]};
                rvseed_pkg::MEM_LBU: data = (dword >> (8 * res[2:0])) & 64'hff;
                default:             data = res;
            endcase
            e.wb.we   = (r.rd != '0);
            e.wb.rd   = r.rd;
            e.wb.data = data;
            if (r.rd != '0) begin
                m_regs[r.rd] = data;
            end
        end
        exp_q.push_back(e);
        @(posedge clk);
        issue <= 1'b1;
        req   <= r;
    endtask

    task automatic idle();
        @(posedge clk);
        issue <= 1'b0;
    endtask

    task automatic check_wb(input rvseed_pkg::wb_t exp);
        if (!wb_valid || br_valid) begin
            abort_run($sformatf("expected a writeback at %0t but a branch result came", $time));
        end else if ((wb.we !== exp.we) ||
                     (exp.we && ((wb.rd !== exp.rd) || (wb.data !== exp.data)))) begin
            abort_run($sformatf("[FAIL] %0t: writeback we=%0b rd=%0d data=%h, expected %0b %0d %h",
                                $time, wb.we, wb.rd, wb.data, exp.we, exp.rd, exp.data));
        end
    endtask

    task automatic check_br(input logic exp_taken);
        if (!br_valid || wb_valid || wb.we) begin
            abort_run($sformatf("expected a branch result at %0t but a writeback came", $time));
        end else if (br_taken !== exp_taken) begin
            abort_run($sformatf("[FAIL] %0t: br_taken=%0b, expected %0b",
                                $time, br_taken, exp_taken));
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (u_dut.u_assert.fail_count != 0) begin
            abort_run($sformatf("an assertion in the bound checker failed before %0t", $time));
        end else if (arst_n && (wb_valid || br_valid)) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("result strobe at %0t with no operation outstanding", $time));
            end else begin
                head = exp_q.pop_front();
                if (head.is_br) begin
                    check_br(head.taken);
                end else begin
                    check_wb(head.wb);
                end
            end
        end
    end

    task automatic fill_and_alu_ops();
        for (int r = 1; r < 32; r++) begin
            send(imm_req(rvseed_pkg::ALU_ADD, 5'(r), 5'd0, rand64()));
        end
        for (int i = 0; i < N_ALU; i++) begin
            send(rr_req(pick_op(rand_below(10)), rand_reg(), rand_reg(), rand_reg()));
            if (rand_below(4) == 0) begin
                idle();
            end
        end
    endtask

    task automatic word_div_ops();
        logic [63:0] imm;
        send(imm_req(rvseed_pkg::ALU_ADD, 5'd1, 5'd0, 64'hffff_ffff_8000_0000));
        send(imm_req(rvseed_pkg::ALU_DIVW, 5'd2, 5'd1, '1)); // most negative / -1
        send(imm_req(rvseed_pkg::ALU_DIVW, 5'd3, 5'd1, 64'd0));
        send(rr_req(rvseed_pkg::ALU_DIVW, 5'd4, 5'd5, 5'd0));
        send(rr_req(rvseed_pkg::ALU_REMU, 5'd6, 5'd7, 5'd0));
        send(imm_req(rvseed_pkg::ALU_ADDW, 5'd8, 5'd0, 64'h7fff_ffff));
        send(imm_req(rvseed_pkg::ALU_ADDW, 5'd9, 5'd8, 64'd1));
        send(imm_req(rvseed_pkg::ALU_ADD, 5'd10, 5'd0, 64'd1));
        send(imm_req(rvseed_pkg::ALU_SLLW, 5'd11, 5'd10, 64'd31));
        send(imm_req(rvseed_pkg::ALU_SLLW, 5'd12, 5'd10, 64'd63)); // only 5 bits count
        for (int i = 0; i < N_WORD; i++) begin
            imm = (rand_below(8) == 0) ? 64'd0 : rand64();
            if (rand_below(2) == 0) begin
                send(imm_req(pick_op(10 + rand_below(4)), rand_reg(), rand_reg(), imm));
            end else begin
                send(rr_req(pick_op(10 + rand_below(4)), rand_reg(), rand_reg(), rand_reg()));
            end
        end
    endtask

    task automatic branch_ops();
        rvseed_pkg::reg_idx_t ra;
        for (int i = 0; i < N_BR; i++) begin
            ra = rand_reg();
            if (rand_below(3) == 0) begin
                send(rr_req(pick_op(14 + rand_below(3)), rand_dest(), ra, ra)); // equal operands
            end else begin
                send(rr_req(pick_op(14 + rand_below(3)), rand_dest(), ra, rand_reg()));
            end
        end
    endtask

    task automatic load_store_ops();
        for (int w = 0; w < MEM_WORDS; w++) begin
            send(mem_req(rvseed_pkg::MEM_SD, rand_reg(), 5'd0, rand_reg(), 64'(w * 8)));
        end
        for (int i = 0; i < N_LDST; i++) begin
            if (rand_below(8) == 0) begin
                send(mem_req(rvseed_pkg::MEM_SD, rand_reg(), rand_reg(), rand_reg(), rand64()));
            end else if (rand_below(2) == 0) begin
                send(mem_req(rand_load(), rand_reg(), 5'd0, 5'd0, 64'(rand_below(MEM_WORDS * 8))));
            end else begin
                send(mem_req(rand_load(), rand_reg(), rand_reg(), 5'd0, rand64())); // wraps
            end
            if (rand_below(5) == 0) begin
                idle();
            end
        end
    endtask

    task automatic forward_chains();
        rvseed_pkg::reg_idx_t ra;
        rvseed_pkg::reg_idx_t rb;
        for (int i = 0; i < N_FWD; i++) begin
            ra = rand_dest();
            rb = rand_dest();
            send(imm_req(rvseed_pkg::ALU_ADD, ra, 5'd0, 64'(rand_below(MEM_WORDS * 8))));
            send(mem_req(rvseed_pkg::MEM_SD, rand_reg(), ra, rand_reg(), 64'd0)); // base forwarded
            send(mem_req(rand_load(), rb, ra, 5'd0, 64'(rand_below(8))));
            send(rr_req(pick_op(rand_below(10)), rand_reg(), rb, ra)); // load result forwarded
        end
        send(imm_req(rvseed_pkg::ALU_ADD, 5'd20, 5'd0, rand64()));
        send(mem_req(rvseed_pkg::MEM_SD, 5'd0, 5'd0, 5'd20, 64'h40)); // store data forwarded
        send(mem_req(rvseed_pkg::MEM_LD, 5'd21, 5'd0, 5'd0, 64'h40));
    endtask

    task automatic zero_reg_ops();
        send(imm_req(rvseed_pkg::ALU_ADD, 5'd0, 5'd0, rand64()));
        send(rr_req(rvseed_pkg::ALU_OR, 5'd0, 5'd1, 5'd2));
        send(mem_req(rvseed_pkg::MEM_LD, 5'd0, 5'd0, 5'd0, 64'd8));
        send(rr_req(rvseed_pkg::ALU_ADD, 5'd13, 5'd0, 5'd0)); // x0 still zero
        send(rr_req(rvseed_pkg::ALU_XOR, 5'd14, 5'd0, 5'd13));
    endtask

    initial begin
        seed   = 20;
        issue  = 1'b0;
        req    = '0;
        arst_n = 1'b0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        fill_and_alu_ops();
        word_div_ops();
        branch_ops();
        load_store_ops();
        forward_chains();
        zero_reg_ops();
        idle();
        drain = 0;
        while ((exp_q.size() != 0) && (drain < 10)) begin
            @(posedge clk);
            drain++;
        end
        repeat (3) @(posedge clk); // catch stray strobes
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d results never arrived", exp_q.size()));
        end else if (u_dut.u_assert.fail_count != 0) begin
            abort_run($sformatf("%0d assertion failures in the bound checker",
                                u_dut.u_assert.fail_count));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bench/rvseed_ex_assert.sv
`default_nettype none

module rvseed_ex_assert (
    input logic            clk,
    input logic            arst_n,
    input logic            issue,
    input logic            wb_valid,
    input rvseed_pkg::wb_t wb,
    input logic            br_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // one result strobe two edges after each issue
    a_issue_to_result: assert property (@(posedge clk) disable iff (!arst_n)
        issue |-> ##2 (wb_valid || br_valid))
        else begin
            fail_count++;
            $error("no result strobe two edges after issue");
        end

    a_result_from_issue: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_valid || br_valid) |-> $past(issue, 2))
        else begin
            fail_count++;
            $error("result strobe without a matching issue");
        end

    a_quiet_in_reset: assert property (@(negedge clk)
        !arst_n |-> (!wb_valid && !br_valid))
        else begin
            fail_count++;
            $error("result strobe during reset");
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        wb.we |-> (wb.rd != '0))
        else begin
            fail_count++;
            $error("write enable with rd zero");
        end

    a_branch_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(br_valid && wb.we))
        else begin
            fail_count++;
            $error("branch result with write enable");
        end

endmodule

bind rvseed_ex_top rvseed_ex_assert u_assert (
    .clk      (clk),
    .arst_n   (arst_n),
    .issue    (issue),
    .wb_valid (wb_valid),
    .wb       (wb),
    .br_valid (br_valid)
);

`default_nettype wire

// File: rtl/rvseed_ex_top.sv
`default_nettype none

module rvseed_ex_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 issue,
    input  rvseed_pkg::ex_req_t  req,
    output logic                 wb_valid,
    output rvseed_pkg::wb_t      wb,
    output logic                 br_valid,
    output logic                 br_taken
);

    rvseed_pkg::reg_idx_t        raddr1;
    rvseed_pkg::reg_idx_t        raddr2;
    logic [rvseed_pkg::XLEN-1:0] rdata1;
    logic [rvseed_pkg::XLEN-1:0] rdata2;
    rvseed_pkg::alu_op_e         alu_op;
    logic [rvseed_pkg::XLEN-1:0] src1;
    logic [rvseed_pkg::XLEN-1:0] src2;
    logic [rvseed_pkg::XLEN-1:0] alu_res;
    logic                        taken;
    logic [rvseed_pkg::XLEN-1:0] mem_addr;
    rvseed_pkg::mem_op_e         mem_op;
    logic [rvseed_pkg::XLEN-1:0] st_data;
    logic [rvseed_pkg::XLEN-1:0] load_data;
    logic                        rf_we;
    rvseed_pkg::reg_idx_t        rf_waddr;
    logic [rvseed_pkg::XLEN-1:0] rf_wdata;

    ex_pipe u_pipe (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (issue),
        .req       (req),
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .alu_op    (alu_op),
        .src1      (src1),
        .src2      (src2),
        .alu_res   (alu_res),
        .taken     (taken),
        .mem_addr  (mem_addr),
        .mem_op    (mem_op),
        .st_data   (st_data),
        .load_data (load_data),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .wb_valid  (wb_valid),
        .wb        (wb),
        .br_valid  (br_valid),
        .br_taken  (br_taken)
    );

    rvseed_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    alu u_alu (
        .alu_op  (alu_op),
        .src1    (src1),
        .src2    (src2),
        .alu_res (alu_res),
        .taken   (taken)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dmem (
        .clk       (clk),
        .addr      (mem_addr),
        .mem_op    (mem_op),
        .wdata     (st_data),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

// File: rtl/ex_pipe.sv
`default_nettype none

module ex_pipe (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         issue,
    input  rvseed_pkg::ex_req_t          req,
    output rvseed_pkg::reg_idx_t         raddr1,
    output rvseed_pkg::reg_idx_t         raddr2,
    input  logic [rvseed_pkg::XLEN-1:0]  rdata1,
    input  logic [rvseed_pkg::XLEN-1:0]  rdata2,
    output rvseed_pkg::alu_op_e          alu_op,
    output logic [rvseed_pkg::XLEN-1:0]  src1,
    output logic [rvseed_pkg::XLEN-1:0]  src2,
    input  logic [rvseed_pkg::XLEN-1:0]  alu_res,
    input  logic                         taken,
    output logic [rvseed_pkg::XLEN-1:0]  mem_addr,
    output rvseed_pkg::mem_op_e          mem_op,
    output logic [rvseed_pkg::XLEN-1:0]  st_data,
    input  logic [rvseed_pkg::XLEN-1:0]  load_data,
    output logic                         rf_we,
    output rvseed_pkg::reg_idx_t         rf_waddr,
    output logic [rvseed_pkg::XLEN-1:0]  rf_wdata,
    output logic                         wb_valid,
    output rvseed_pkg::wb_t              wb,
    output logic                         br_valid,
    output logic                         br_taken
);

    logic                        s1_valid;
    rvseed_pkg::ex_req_t         s1_req;
    logic [rvseed_pkg::XLEN-1:0] opa;
    logic [rvseed_pkg::XLEN-1:0] opb;
    logic                        is_branch;
    logic                        is_load;
    logic                        s1_we;
    rvseed_pkg::wb_t             s1_wb;

    // stage 1: issue register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s1_req   <= '0;
        end else begin
            s1_valid <= issue;
            if (issue) begin
                s1_req <= req;
            end
        end
    end

    assign raddr1 = s1_req.rs1;
    assign raddr2 = s1_req.rs2;

    // forward from stage 2, we implies rd != 0
    assign opa = (wb.we && (wb.rd == s1_req.rs1)) ? wb.data : rdata1;
    assign opb = (wb.we && (wb.rd == s1_req.rs2)) ? wb.data : rdata2;

    assign alu_op   = s1_req.alu_op;
    assign src1     = opa;
    assign src2     = s1_req.use_imm ? s1_req.imm : opb;
    assign mem_addr = alu_res;
    assign st_data  = opb;
    assign mem_op   = s1_valid ? s1_req.mem_op : rvseed_pkg::MEM_NONE; // no stray store on bubble

    assign is_branch = (s1_req.alu_op == rvseed_pkg::ALU_BEQ) ||
                       (s1_req.alu_op == rvseed_pkg::ALU_BNE) ||
                       (s1_req.alu_op == rvseed_pkg::ALU_BLT);
    assign is_load   = (s1_req.mem_op == rvseed_pkg::MEM_LWU) ||
                       (s1_req.mem_op == rvseed_pkg::MEM_LD) ||
                       (s1_req.mem_op == rvseed_pkg::MEM_LBU);
    assign s1_we     = s1_valid && !is_branch && (s1_req.mem_op != rvseed_pkg::MEM_SD) &&
                       (s1_req.rd != '0);

    assign s1_wb.we   = s1_we;
    assign s1_wb.rd   = s1_req.rd;
    assign s1_wb.data = is_load ? load_data : alu_res;

    // stage 2: output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb       <= '0;
            br_valid <= 1'b0;
            br_taken <= 1'b0;
        end else begin
            wb_valid <= s1_valid && !is_branch;
            wb       <= s1_wb;
            br_valid <= s1_valid && is_branch;
            br_taken <= s1_valid && is_branch && taken;
        end
    end

    assign rf_we    = wb.we; // written one edge after capture
    assign rf_waddr = wb.rd;
    assign rf_wdata = wb.data;

endmodule

`default_nettype wire

// File: mem/data_mem.sv
`default_nettype none

module data_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic [rvseed_pkg::XLEN-1:0]  addr,
    input  rvseed_pkg::mem_op_e          mem_op,
    input  logic [rvseed_pkg::XLEN-1:0]  wdata,
    output logic [rvseed_pkg::XLEN-1:0]  load_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [rvseed_pkg::XLEN-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0]            idx;
    logic [rvseed_pkg::XLEN-1:0] dword;
    logic [31:0]                 word;
    logic [7:0]                  byte_sel;

    assign idx      = addr[IDX_W+2:3]; // upper address bits wrap
    assign dword    = mem[idx];
    assign word     = addr[2] ? dword[63:32] : dword[31:0];
    assign byte_sel = dword[{addr[2:0], 3'b000} +: 8];

    always_comb begin
        case (mem_op)
            rvseed_pkg::MEM_LD: begin
                load_data = dword; // offset ignored
            end
            rvseed_pkg::MEM_LWU: begin
                load_data = {{(rvseed_pkg::XLEN-32){1'b0}}, word};
            end
            rvseed_pkg::MEM_LBU: begin
                load_data = {{(rvseed_pkg::XLEN-8){1'b0}}, byte_sel};
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

    // doubleword store, offset bits ignored
    always_ff @(posedge clk) begin
        if (mem_op == rvseed_pkg::MEM_SD) begin
            mem[idx] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rvseed_regfile.sv
`default_nettype none

module rvseed_regfile (
    input  logic                         clk,
    input  logic                         arst_n,
    input  rvseed_pkg::reg_idx_t         raddr1,
    input  rvseed_pkg::reg_idx_t         raddr2,
    output logic [rvseed_pkg::XLEN-1:0]  rdata1,
    output logic [rvseed_pkg::XLEN-1:0]  rdata2,
    input  logic                         we,
    input  rvseed_pkg::reg_idx_t         waddr,
    input  logic [rvseed_pkg::XLEN-1:0]  wdata
);

    logic [rvseed_pkg::XLEN-1:0] regs [1:31]; // no storage for x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none

module alu (
    input  rvseed_pkg::alu_op_e          alu_op,
    input  logic [rvseed_pkg::XLEN-1:0]  src1,
    input  logic [rvseed_pkg::XLEN-1:0]  src2,
    output logic [rvseed_pkg::XLEN-1:0]  alu_res,
    output logic                         taken
);

    logic signed [rvseed_pkg::XLEN-1:0] s1;
    logic signed [rvseed_pkg::XLEN-1:0] s2;
    logic [5:0]                         shamt;
    logic [31:0]                        add_w;
    logic [31:0]                        sll_w;
    logic signed [31:0]                 dvd_w;
    logic signed [31:0]                 dvs_w;
    logic signed [31:0]                 quo_w;
    logic [rvseed_pkg::XLEN-1:0]        rem_u;

    assign s1    = src1;
    assign s2    = src2;
    assign shamt = src2[5:0];
    assign add_w = src1[31:0] + src2[31:0];
    assign sll_w = src1[31:0] << src2[4:0]; // word shift uses 5 bits
    assign dvd_w = src1[31:0];
    assign dvs_w = src2[31:0];

    always_comb begin
        if (dvs_w == 32'sd0) begin
            quo_w = '1; // div by zero gives -1
        end else if (dvs_w == -32'sd1) begin
            quo_w = 32'sd0 - dvd_w; // wraps on most negative
        end else begin
            quo_w = dvd_w / dvs_w;
        end
    end

    assign rem_u = (src2 == '0) ? src1 : src1 % src2; // remu by zero keeps dividend

    always_comb begin
        alu_res = '0;
        taken   = 1'b0;
        case (alu_op)
            rvseed_pkg::ALU_ADD: begin
                alu_res = src1 + src2;
            end
            rvseed_pkg::ALU_SUB: begin
                alu_res = src1 - src2;
            end
            rvseed_pkg::ALU_AND: begin
                alu_res = src1 & src2;
            end
            rvseed_pkg::ALU_OR: begin
                alu_res = src1 | src2;
            end
            rvseed_pkg::ALU_XOR: begin
                alu_res = src1 ^ src2;
            end
            rvseed_pkg::ALU_SLL: begin
                alu_res = src1 << shamt;
            end
            rvseed_pkg::ALU_SRA: begin
                alu_res = s1 >>> shamt;
            end
            rvseed_pkg::ALU_SLTU: begin
                alu_res = {{(rvseed_pkg::XLEN-1){1'b0}}, src1 < src2};
            end
            rvseed_pkg::ALU_SLT: begin
                alu_res = {{(rvseed_pkg::XLEN-1){1'b0}}, s1 < s2};
            end
            rvseed_pkg::ALU_MUL: begin
                alu_res = src1 * src2; // low half only
            end
            rvseed_pkg::ALU_ADDW: begin
                alu_res = {{(rvseed_pkg::XLEN-32){add_w[31]}}, add_w};
            end
            rvseed_pkg::ALU_SLLW: begin
                alu_res = {{(rvseed_pkg::XLEN-32){sll_w[31]}}, sll_w};
            end
            rvseed_pkg::ALU_DIVW: begin
                alu_res = {{(rvseed_pkg::XLEN-32){quo_w[31]}}, quo_w};
            end
            rvseed_pkg::ALU_REMU: begin
                alu_res = rem_u;
            end
            rvseed_pkg::ALU_BEQ: begin
                taken = (src1 == src2);
            end
            rvseed_pkg::ALU_BNE: begin
                taken = (src1 != src2);
            end
            rvseed_pkg::ALU_BLT: begin
                taken = (s1 < s2);
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: common/rvseed_pkg.sv
`default_nettype none

package rvseed_pkg;

    localparam int XLEN = 64; // datapath width

    typedef logic [4:0] reg_idx_t; // x0..x31

    // alu opcodes, branches at the top of the range
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRA  = 5'd6,
        ALU_SLTU = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_MUL  = 5'd9,
        ALU_ADDW = 5'd10,
        ALU_SLLW = 5'd11,
        ALU_DIVW = 5'd12,
        ALU_REMU = 5'd13,
        ALU_BEQ  = 5'd16,
        ALU_BNE  = 5'd17,
        ALU_BLT  = 5'd18
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_NONE = 3'd0,
        MEM_LWU  = 3'd1, // zero-extended word
        MEM_LD   = 3'd2,
        MEM_LBU  = 3'd4, // zero-extended byte
        MEM_SD   = 3'd5
    } mem_op_e;

    // one issued operation
    typedef struct packed {
        alu_op_e         alu_op;
        mem_op_e         mem_op;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        reg_idx_t        rd;
        logic            use_imm; // second operand from imm
        logic [XLEN-1:0] imm;
    } ex_req_t;

    // one writeback
    typedef struct packed {
        logic            we;
        reg_idx_t        rd;
        logic [XLEN-1:0] data;
    } wb_t;

endpackage

`default_nettype wire
